//--- design/rv32_pkg.sv
// rv32 execute stage shared types
// opcodes, funct3 codes, control selects, instruction formats and stage structs
package rv32_pkg;

  typedef logic [31:0] word_t;

  // major opcodes of the base integer set
  typedef enum logic [6:0] {
    OP_LUI    = 7'b0110111,
    OP_AUIPC  = 7'b0010111,
    OP_JAL    = 7'b1101111,
    OP_JALR   = 7'b1100111,
    OP_BRANCH = 7'b1100011,
    OP_LOAD   = 7'b0000011,
    OP_STORE  = 7'b0100011,
    OP_IMM    = 7'b0010011,
    OP_REG    = 7'b0110011,
    OP_SYSTEM = 7'b1110011
  } opcode_e;

  // load funct3, stores reuse LB, LH and LW
  typedef enum logic [2:0] {
    LB  = 3'b000,
    LH  = 3'b001,
    LW  = 3'b010,
    LBU = 3'b100,
    LHU = 3'b101
  } mem_size_e;

  typedef enum logic [2:0] {
    BEQ  = 3'b000,
    BNE  = 3'b001,
    BLT  = 3'b100,
    BGE  = 3'b101,
    BLTU = 3'b110,
    BGEU = 3'b111
  } br_type_e;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
    ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
  } alu_op_e;

  typedef enum logic {A_RS1, A_PC} a_sel_e;
  typedef enum logic {B_RS2, B_IMM} b_sel_e;

  // write-back source
  typedef enum logic [1:0] {W_ALU, W_LOAD, W_PC4, W_IMM} w_sel_e;

  // instruction formats, all 32 bits wide
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    opcode_e    opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    opcode_e     opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0] imm_hi;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;
    opcode_e    opcode;
  } s_fmt_t;

  typedef struct packed {
    logic       imm_12;
    logic [5:0] imm_10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm_4_1;
    logic       imm_11;
    opcode_e    opcode;
  } b_fmt_t;

  typedef struct packed {
    logic [19:0] imm_31_12;
    logic [4:0]  rd;
    opcode_e     opcode;
  } u_fmt_t;

  typedef struct packed {
    logic       imm_20;
    logic [9:0] imm_10_1;
    logic       imm_11;
    logic [7:0] imm_19_12;
    logic [4:0] rd;
    opcode_e    opcode;
  } j_fmt_t;

  // one word seen through every format
  typedef union packed {
    logic [31:0] raw;
    r_fmt_t      r_fmt;
    i_fmt_t      i_fmt;
    s_fmt_t      s_fmt;
    b_fmt_t      b_fmt;
    u_fmt_t      u_fmt;
    j_fmt_t      j_fmt;
  } instr_u;

  // decoded control for one instruction
  typedef struct packed {
    logic [4:0] rs1;
    logic [4:0] rs2;
    logic [4:0] rd;
    alu_op_e    alu_op;
    a_sel_e     a_sel;
    b_sel_e     b_sel;
    w_sel_e     w_sel;
    logic       reg_wen;
    logic       mem_ren;
    logic       mem_wen;
    mem_size_e  mem_size;
    logic       branch;
    logic       jump;
    logic       jalr;
    br_type_e   br_type;
    logic       halt;
    logic       illegal;
    logic       ecall;
    logic       ebreak;
  } ctrl_t;

  // registered handoff from fetch
  typedef struct packed {
    instr_u instr;
    word_t  pc;
    logic   prediction;
  } fetch_ex_t;

  typedef struct packed {
    logic       ren;
    logic       wen;
    word_t      addr;
    logic [3:0] byte_en;
    word_t      wdata;
  } dmem_req_t;

  typedef struct packed {
    logic illegal;
    logic mal_load;
    logic mal_store;
    logic ecall;
    logic ebreak;
  } exc_t;

endpackage

//--- design/instr_decoder.sv
// instruction decoder
// maps an instruction word to control fields and its sign-extended immediate
`timescale 1ns/1ps

module instr_decoder import rv32_pkg::*; (
  input  instr_u instr,
  output ctrl_t  ctrl,
  output word_t  imm
);

  logic [2:0] f3;
  logic [6:0] f7;
  logic       bad;
  word_t      imm_i, imm_s, imm_b, imm_u, imm_j;

  // funct3 and funct7 share their positions across formats
  assign f3 = instr.r_fmt.funct3;
  assign f7 = instr.r_fmt.funct7;

  // immediates rebuilt from the scattered format fields
  assign imm_i = {{20{instr.i_fmt.imm[11]}}, instr.i_fmt.imm};
  assign imm_s = {{20{instr.s_fmt.imm_hi[6]}}, instr.s_fmt.imm_hi, instr.s_fmt.imm_lo};
  assign imm_b = {{19{instr.b_fmt.imm_12}}, instr.b_fmt.imm_12, instr.b_fmt.imm_11,
                  instr.b_fmt.imm_10_5, instr.b_fmt.imm_4_1, 1'b0};
  assign imm_u = {instr.u_fmt.imm_31_12, 12'b0};
  assign imm_j = {{11{instr.j_fmt.imm_20}}, instr.j_fmt.imm_20, instr.j_fmt.imm_19_12,
                  instr.j_fmt.imm_11, instr.j_fmt.imm_10_1, 1'b0};

  // funct3 to alu op, alt picks sub and sra
  function automatic alu_op_e f3_to_alu(input logic [2:0] sel, input logic alt);
    alu_op_e op;
    case (sel)
      3'b000:  op = alt ? ALU_SUB : ALU_ADD;
      3'b001:  op = ALU_SLL;
      3'b010:  op = ALU_SLT;
      3'b011:  op = ALU_SLTU;
      3'b100:  op = ALU_XOR;
      3'b101:  op = alt ? ALU_SRA : ALU_SRL;
      3'b110:  op = ALU_OR;
      default: op = ALU_AND;
    endcase
    return op;
  endfunction

  always_comb begin
    bad           = 1'b0;
    ctrl          = '0;
    ctrl.rs1      = instr.r_fmt.rs1;
    ctrl.rs2      = instr.r_fmt.rs2;
    ctrl.rd       = instr.r_fmt.rd;
    ctrl.alu_op   = ALU_ADD;
    ctrl.a_sel    = A_RS1;
    ctrl.b_sel    = B_IMM;
    ctrl.w_sel    = W_ALU;
    ctrl.mem_size = mem_size_e'(f3);
    ctrl.br_type  = br_type_e'(f3);
    imm           = imm_i;
    case (instr.r_fmt.opcode)
      OP_LUI: begin
        imm          = imm_u;
        ctrl.w_sel   = W_IMM;
        ctrl.reg_wen = 1'b1;
      end
      OP_AUIPC: begin
        imm          = imm_u;
        ctrl.a_sel   = A_PC;
        ctrl.reg_wen = 1'b1;
      end
      OP_JAL: begin
        imm          = imm_j;
        ctrl.w_sel   = W_PC4;
        ctrl.reg_wen = 1'b1;
        ctrl.jump    = 1'b1;
      end
      OP_JALR: begin
        // link is pc+4, target from rs1 in the branch unit
        bad          = (f3 != 3'b000);
        ctrl.w_sel   = W_PC4;
        ctrl.reg_wen = 1'b1;
        ctrl.jump    = 1'b1;
        ctrl.jalr    = 1'b1;
      end
      OP_BRANCH: begin
        // funct3 010 and 011 are unused
        bad         = (f3[2:1] == 2'b01);
        imm         = imm_b;
        ctrl.b_sel  = B_RS2;
        ctrl.branch = 1'b1;
      end
      OP_LOAD: begin
        bad          = (f3 == 3'b011) || (f3[2:1] == 2'b11);
        ctrl.w_sel   = W_LOAD;
        ctrl.reg_wen = 1'b1;
        ctrl.mem_ren = 1'b1;
      end
      OP_STORE: begin
        // only byte, half and word
        bad          = f3[2] || (f3 == 3'b011);
        imm          = imm_s;
        ctrl.mem_wen = 1'b1;
      end
      OP_IMM: begin
        // shift immediates carry funct7 in imm[11:5]
        if (f3 == 3'b001) bad = (f7 != 7'b0000000);
        if (f3 == 3'b101) bad = (f7 != 7'b0000000) && (f7 != 7'b0100000);
        ctrl.alu_op  = f3_to_alu(f3, (f3 == 3'b101) && f7[5]);
        ctrl.reg_wen = 1'b1;
      end
      OP_REG: begin
        // alternate funct7 only for sub and sra
        bad          = !((f7 == 7'b0000000) ||
                         ((f7 == 7'b0100000) && ((f3 == 3'b000) || (f3 == 3'b101))));
        ctrl.alu_op  = f3_to_alu(f3, f7[5]);
        ctrl.b_sel   = B_RS2;
        ctrl.reg_wen = 1'b1;
      end
      OP_SYSTEM: begin
        ctrl.ecall  = (instr.raw == 32'h0000_0073);
        ctrl.ebreak = (instr.raw == 32'h0010_0073);
        ctrl.halt   = ctrl.ebreak;
        bad         = !(ctrl.ecall || ctrl.ebreak);
      end
      default: bad = 1'b1;
    endcase
    // an illegal word has no side effects
    ctrl.illegal = bad;
    if (bad) begin
      ctrl.reg_wen = 1'b0;
      ctrl.mem_ren = 1'b0;
      ctrl.mem_wen = 1'b0;
      ctrl.branch  = 1'b0;
      ctrl.jump    = 1'b0;
      ctrl.jalr    = 1'b0;
    end
  end

  // no opcode class may request both a load and a store
  always_comb begin
    assert final (!(ctrl.mem_ren && ctrl.mem_wen))
      else $error("decoder drives mem_ren and mem_wen together");
  end

endmodule

//--- design/reg_file.sv
// integer register file
// 32 x 32 bits, two combinational read ports, one write port, x0 reads zero
`timescale 1ns/1ps

module reg_file import rv32_pkg::*; (
  input  logic       CLK,
  input  logic       arst_n,
  input  logic [4:0] rs1_idx,
  input  logic [4:0] rs2_idx,
  input  logic [4:0] rd_idx,
  input  logic       wen,
  input  word_t      wdata,
  output word_t      rs1_data,
  output word_t      rs2_data
);

  word_t regs [32];

  // entry 0 only sees reset, writes to rd 0 are dropped
  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      regs <= '{default: '0};
    end else if (wen && (rd_idx != 5'd0)) begin
      regs[rd_idx] <= wdata;
    end
  end

  // no bypass, a write shows up on the next cycle
  assign rs1_data = regs[rs1_idx];
  assign rs2_data = regs[rs2_idx];

  // x0 stays zero however long the run
  assert property (@(posedge CLK) disable iff (!arst_n) regs[0] == '0)
    else $error("register x0 lost its zero value");

endmodule

//--- design/alu.sv
// integer ALU
// add, sub, shifts, set-less-than and bitwise ops of the base set
`timescale 1ns/1ps

module alu import rv32_pkg::*; (
  input  alu_op_e op,
  input  word_t   a,
  input  word_t   b,
  output word_t   out
);

  logic [4:0] shamt;

  // shift amount from the low five bits only
  assign shamt = b[4:0];

  always_comb begin
    case (op)
      ALU_ADD:  out = a + b;
      ALU_SUB:  out = a - b;
      ALU_SLL:  out = a << shamt;
      ALU_SLT:  out = {31'b0, $signed(a) < $signed(b)};
      ALU_SLTU: out = {31'b0, a < b};
      ALU_XOR:  out = a ^ b;
      ALU_SRL:  out = a >> shamt;
      // arithmetic shift keeps the sign
      ALU_SRA:  out = word_t'($signed(a) >>> shamt);
      ALU_OR:   out = a | b;
      ALU_AND:  out = a & b;
      default:  out = '0;
    endcase
  end

endmodule

//--- design/branch_unit.sv
// branch and jump resolution
// compares operands, forms the redirect address and the mispredict flag
`timescale 1ns/1ps

module branch_unit import rv32_pkg::*; #(
  parameter word_t RESET_PC = 32'h0000_0000
) (
  input  logic  arst_n,
  input  ctrl_t ctrl,
  input  word_t pc,
  input  word_t imm,
  input  word_t rs1_data,
  input  word_t rs2_data,
  input  logic  prediction,
  output word_t brj_addr,
  output logic  taken,
  output logic  mispredict
);

  logic  eq, lt, ltu, cond;
  word_t next_addr;

  assign eq  = (rs1_data == rs2_data);
  assign lt  = ($signed(rs1_data) < $signed(rs2_data));
  assign ltu = (rs1_data < rs2_data);

  always_comb begin
    case (ctrl.br_type)
      BEQ:     cond = eq;
      BNE:     cond = !eq;
      BLT:     cond = lt;
      BGE:     cond = !lt;
      BLTU:    cond = ltu;
      BGEU:    cond = !ltu;
      default: cond = 1'b0;
    endcase
  end

  assign taken = ctrl.branch & cond;

  // jalr clears bit 0 of the sum
  always_comb begin
    if (ctrl.jalr)                next_addr = (rs1_data + imm) & ~32'h1;
    else if (ctrl.jump || taken)  next_addr = pc + imm;
    else                          next_addr = pc + 32'd4;
  end

  // hold the boot address while in reset
  assign brj_addr   = arst_n ? next_addr : RESET_PC;
  // jumps are always redirected, never counted as mispredicts
  assign mispredict = arst_n & ctrl.branch & (prediction ^ taken);

  // the decoder keeps branch and jump exclusive
  always_comb begin
    assert final (!mispredict || (ctrl.branch && !ctrl.jump && !ctrl.jalr))
      else $error("mispredict raised on a non-branch");
  end

endmodule

//--- design/lsu_align.sv
// load/store alignment
// byte enables, misalignment, store replication and load extension
`timescale 1ns/1ps

module lsu_align import rv32_pkg::*; (
  input  ctrl_t     ctrl,
  input  word_t     addr,
  input  word_t     rs2_data,
  input  word_t     dmem_rdata,
  input  logic      stall,
  output dmem_req_t dmem_req,
  output word_t     load_data,
  output logic      mal_load,
  output logic      mal_store
);

  logic [1:0]  off;
  logic [3:0]  be;
  logic        mis;
  logic [7:0]  lane_b;
  logic [15:0] lane_h;

  assign off = addr[1:0];

  // lanes from size and offset
  always_comb begin
    be  = 4'b0000;
    mis = 1'b0;
    case (ctrl.mem_size)
      LB, LBU: be = 4'b0001 << off;
      LH, LHU: begin
        be  = off[1] ? 4'b1100 : 4'b0011;
        // halves need an even offset
        mis = off[0];
      end
      LW: begin
        be  = 4'b1111;
        mis = (off != 2'b00);
      end
      default: be = 4'b0000;
    endcase
  end

  assign mal_load  = ctrl.mem_ren & mis;
  assign mal_store = ctrl.mem_wen & mis;

  // request dropped on misalignment or stall
  assign dmem_req.ren     = ctrl.mem_ren & ~mis & ~stall;
  assign dmem_req.wen     = ctrl.mem_wen & ~mis & ~stall;
  assign dmem_req.addr    = addr;
  assign dmem_req.byte_en = be;

  // store data copied to every lane, memory picks by byte_en
  always_comb begin
    case (ctrl.mem_size)
      LB:      dmem_req.wdata = {4{rs2_data[7:0]}};
      LH:      dmem_req.wdata = {2{rs2_data[15:0]}};
      default: dmem_req.wdata = rs2_data;
    endcase
  end

  // addressed lane of the returned word
  assign lane_b = dmem_rdata[{off, 3'b000} +: 8];
  assign lane_h = off[1] ? dmem_rdata[31:16] : dmem_rdata[15:0];

  always_comb begin
    case (ctrl.mem_size)
      LB:      load_data = {{24{lane_b[7]}}, lane_b};
      LH:      load_data = {{16{lane_h[15]}}, lane_h};
      LBU:     load_data = {24'b0, lane_b};
      LHU:     load_data = {16'b0, lane_h};
      default: load_data = dmem_rdata;
    endcase
  end

endmodule

//--- design/execute_stage.sv
// execute stage of the two-stage pipeline
// decode, register read, alu, branch resolve, memory access and write-back
`timescale 1ns/1ps

module execute_stage import rv32_pkg::*; #(
  parameter word_t RESET_PC = 32'h0000_0200
) (
  input  logic      CLK,
  input  logic      arst_n,
  input  fetch_ex_t fetch_ex,
  input  logic      stall,
  input  word_t     dmem_rdata,
  output dmem_req_t dmem_req,
  output word_t     brj_addr,
  output logic      mispredict,
  output logic      halt,
  output exc_t      exc
);

  ctrl_t ctrl;
  word_t pc, imm, rs1_data, rs2_data;
  word_t alu_a, alu_b, alu_out, load_data, wb_data;
  logic  taken, mal_load, mal_store, hold, rf_wen;

  assign pc = fetch_ex.pc;

  instr_decoder u_dec (
    .instr(fetch_ex.instr),
    .ctrl (ctrl),
    .imm  (imm)
  );

  // writes blocked by stall and by reset
  assign hold = stall | ~arst_n;
  // a misaligned load must not touch rd
  assign rf_wen = ctrl.reg_wen & ~hold & ~mal_load;

  reg_file u_rf (
    .CLK     (CLK),
    .arst_n  (arst_n),
    .rs1_idx (ctrl.rs1),
    .rs2_idx (ctrl.rs2),
    .rd_idx  (ctrl.rd),
    .wen     (rf_wen),
    .wdata   (wb_data),
    .rs1_data(rs1_data),
    .rs2_data(rs2_data)
  );

  // operand muxes
  assign alu_a = (ctrl.a_sel == A_PC)  ? pc  : rs1_data;
  assign alu_b = (ctrl.b_sel == B_IMM) ? imm : rs2_data;

  alu u_alu (
    .op (ctrl.alu_op),
    .a  (alu_a),
    .b  (alu_b),
    .out(alu_out)
  );

  branch_unit #(.RESET_PC(RESET_PC)) u_br (
    .arst_n    (arst_n),
    .ctrl      (ctrl),
    .pc        (pc),
    .imm       (imm),
    .rs1_data  (rs1_data),
    .rs2_data  (rs2_data),
    .prediction(fetch_ex.prediction),
    .brj_addr  (brj_addr),
    .taken     (taken),
    .mispredict(mispredict)
  );

  // address comes straight from the alu sum
  lsu_align u_lsu (
    .ctrl      (ctrl),
    .addr      (alu_out),
    .rs2_data  (rs2_data),
    .dmem_rdata(dmem_rdata),
    .stall     (hold),
    .dmem_req  (dmem_req),
    .load_data (load_data),
    .mal_load  (mal_load),
    .mal_store (mal_store)
  );

  // write-back source
  always_comb begin
    case (ctrl.w_sel)
      W_ALU:   wb_data = alu_out;
      W_LOAD:  wb_data = load_data;
      W_PC4:   wb_data = pc + 32'd4;
      default: wb_data = imm;
    endcase
  end

  assign halt = ctrl.halt;

  // flags only, nothing is trapped here
  assign exc.illegal   = ctrl.illegal;
  assign exc.mal_load  = mal_load;
  assign exc.mal_store = mal_store;
  assign exc.ecall     = ctrl.ecall;
  assign exc.ebreak    = ctrl.ebreak;

  // a taken branch redirects to pc + imm across decoder and branch unit
  assert property (@(posedge CLK) disable iff (!arst_n) taken |-> (brj_addr == pc + imm))
    else $error("taken branch with wrong redirect address");

endmodule

//--- dv/execute_stage_tb.sv
// execute stage testbench
// instruction table with model-derived expectations, applied one row per cycle
`timescale 1ns/1ps

module execute_stage_tb import rv32_pkg::*; ();

  localparam int    CLK_PERIOD  = 8;
  localparam int    CHECK_DELAY = CLK_PERIOD / 2 - 1;
  localparam word_t RESET_PC    = 32'h0000_0400;

  // one cycle of stimulus and the response it should produce
  typedef struct packed {
    word_t     instr;
    word_t     pc;
    logic      pred;
    logic      stall;
    word_t     rdata;
    word_t     exp_brj;
    logic      exp_misp;
    dmem_req_t exp_req;
    logic      exp_halt;
    exc_t      exp_exc;
  } row_t;

  logic      CLK;
  logic      arst_n;
  fetch_ex_t fetch_ex;
  logic      stall;
  word_t     dmem_rdata;
  dmem_req_t dmem_req;
  word_t     brj_addr;
  logic      mispredict;
  logic      halt;
  exc_t      exc;

  // reference model state
  row_t  rows [$];
  row_t  cur;
  word_t shadow [32];
  word_t model_pc;
  logic  model_stall;
  logic  table_built;
  string where_now;

  execute_stage #(.RESET_PC(RESET_PC)) dut (
    .CLK       (CLK),
    .arst_n    (arst_n),
    .fetch_ex  (fetch_ex),
    .stall     (stall),
    .dmem_rdata(dmem_rdata),
    .dmem_req  (dmem_req),
    .brj_addr  (brj_addr),
    .mispredict(mispredict),
    .halt      (halt),
    .exc       (exc)
  );

  always #(CLK_PERIOD / 2) CLK = ~CLK;

  // instruction encoders, field layout per format
  function automatic word_t enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                  input logic [4:0] rs1, input logic [2:0] f3,
                                  input logic [4:0] rd, input logic [6:0] op);
    return {f7, rs2, rs1, f3, rd, op};
  endfunction

  function automatic word_t enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                  input logic [2:0] f3, input logic [4:0] rd,
                                  input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic word_t enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                  input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], OP_STORE};
  endfunction

  function automatic word_t enc_b(input logic [12:0] off, input logic [4:0] rs2,
                                  input logic [4:0] rs1, input logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OP_BRANCH};
  endfunction

  function automatic word_t enc_j(input logic [20:0] off, input logic [4:0] rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, OP_JAL};
  endfunction

  function automatic word_t sext12(input logic [11:0] v);
    return {{20{v[11]}}, v};
  endfunction

  // integer ops as the ISA defines them
  // alt selects sub and sra
  function automatic word_t alu_ref(input logic [2:0] f3, input logic alt,
                                    input word_t a, input word_t b);
    case (f3)
      3'b000:  return alt ? a - b : a + b;
      3'b001:  return a << b[4:0];
      3'b010:  return {31'b0, $signed(a) < $signed(b)};
      3'b011:  return {31'b0, a < b};
      3'b100:  return a ^ b;
      3'b101:  return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'b110:  return a | b;
      default: return a & b;
    endcase
  endfunction

  // funct3[1:0] is the access width
  function automatic logic is_misaligned(input logic [2:0] f3, input logic [1:0] off);
    case (f3[1:0])
      2'b00:   return 1'b0;
      2'b01:   return off[0];
      default: return off != 2'b00;
    endcase
  endfunction

  function automatic logic [3:0] lane_mask(input logic [2:0] f3, input logic [1:0] off);
    case (f3[1:0])
      2'b00:   return 4'b0001 << off;
      2'b01:   return off[1] ? 4'b1100 : 4'b0011;
      default: return 4'b1111;
    endcase
  endfunction

  function automatic word_t replicate(input logic [2:0] f3, input word_t d);
    case (f3[1:0])
      2'b00:   return {4{d[7:0]}};
      2'b01:   return {2{d[15:0]}};
      default: return d;
    endcase
  endfunction

  function automatic word_t extend_load(input logic [2:0] f3, input word_t rd_word,
                                        input logic [1:0] off);
    word_t lane;
    lane = rd_word >> (8 * off);
    case (f3)
      3'b000:  return {{24{lane[7]}}, lane[7:0]};
      3'b001:  return {{16{lane[15]}}, lane[15:0]};
      3'b100:  return {24'b0, lane[7:0]};
      3'b101:  return {16'b0, lane[15:0]};
      default: return rd_word;
    endcase
  endfunction

  // start a row with the defaults of a plain sequential instruction
  task automatic new_row(input word_t instr);
    cur         = '0;
    cur.instr   = instr;
    cur.pc      = model_pc;
    cur.stall   = model_stall;
    cur.exp_brj = model_pc + 32'd4;
  endtask

  task automatic push_row();
    rows.push_back(cur);
    model_pc = model_pc + 32'd4;
  endtask

  // stall and x0 both drop the write
  task automatic write_reg(input logic [4:0] rd, input word_t val);
    if (!model_stall && rd != 5'd0) shadow[rd] = val;
  endtask

  task automatic m_lui(input logic [4:0] rd, input logic [19:0] imm);
    new_row({imm, rd, OP_LUI});
    write_reg(rd, {imm, 12'b0});
    push_row();
  endtask

  task automatic m_auipc(input logic [4:0] rd, input logic [19:0] imm);
    new_row({imm, rd, OP_AUIPC});
    write_reg(rd, cur.pc + {imm, 12'b0});
    push_row();
  endtask

  task automatic m_alu_imm(input logic [2:0] f3, input logic [4:0] rd,
                           input logic [4:0] rs1, input logic [11:0] imm);
    new_row(enc_i(imm, rs1, f3, rd, OP_IMM));
    write_reg(rd, alu_ref(f3, (f3 == 3'b101) && imm[10], shadow[rs1], sext12(imm)));
    push_row();
  endtask

  task automatic m_alu_reg(input logic [2:0] f3, input logic [6:0] f7, input logic [4:0] rd,
                           input logic [4:0] rs1, input logic [4:0] rs2);
    new_row(enc_r(f7, rs2, rs1, f3, rd, OP_REG));
    write_reg(rd, alu_ref(f3, f7[5], shadow[rs1], shadow[rs2]));
    push_row();
  endtask

  task automatic m_store(input logic [2:0] f3, input logic [4:0] rs1,
                         input logic [4:0] rs2, input logic [11:0] imm);
    word_t addr;
    new_row(enc_s(imm, rs2, rs1, f3));
    addr = shadow[rs1] + sext12(imm);
    if (is_misaligned(f3, addr[1:0])) begin
      cur.exp_exc.mal_store = 1'b1;
    end else begin
      cur.exp_req.wen     = !model_stall;
      cur.exp_req.addr    = addr;
      cur.exp_req.byte_en = lane_mask(f3, addr[1:0]);
      cur.exp_req.wdata   = replicate(f3, shadow[rs2]);
    end
    push_row();
  endtask

  task automatic m_load(input logic [2:0] f3, input logic [4:0] rd, input logic [4:0] rs1,
                        input logic [11:0] imm, input word_t rdata);
    word_t addr;
    new_row(enc_i(imm, rs1, f3, rd, OP_LOAD));
    cur.rdata = rdata;
    addr      = shadow[rs1] + sext12(imm);
    if (is_misaligned(f3, addr[1:0])) begin
      // flagged, and rd keeps its old value
      cur.exp_exc.mal_load = 1'b1;
    end else begin
      cur.exp_req.ren     = !model_stall;
      cur.exp_req.addr    = addr;
      cur.exp_req.byte_en = lane_mask(f3, addr[1:0]);
      write_reg(rd, extend_load(f3, rdata, addr[1:0]));
    end
    push_row();
  endtask

  task automatic m_branch(input logic [2:0] f3, input logic [4:0] rs1, input logic [4:0] rs2,
                          input logic [12:0] off, input logic pred);
    word_t a, b;
    logic  cond;
    new_row(enc_b(off, rs2, rs1, f3));
    a = shadow[rs1];
    b = shadow[rs2];
    case (f3)
      3'b000:  cond = (a == b);
      3'b001:  cond = (a != b);
      3'b100:  cond = ($signed(a) < $signed(b));
      3'b101:  cond = ($signed(a) >= $signed(b));
      3'b110:  cond = (a < b);
      default: cond = (a >= b);
    endcase
    cur.pred = pred;
    if (cond) cur.exp_brj = cur.pc + {{19{off[12]}}, off};
    cur.exp_misp = pred ^ cond;
    push_row();
  endtask

  task automatic m_jal(input logic [4:0] rd, input logic [20:0] off);
    new_row(enc_j(off, rd));
    // a set prediction bit still gives no mispredict on a jump
    cur.pred    = 1'b1;
    cur.exp_brj = cur.pc + {{11{off[20]}}, off};
    write_reg(rd, cur.pc + 32'd4);
    push_row();
  endtask

  task automatic m_jalr(input logic [4:0] rd, input logic [4:0] rs1, input logic [11:0] imm);
    new_row(enc_i(imm, rs1, 3'b000, rd, OP_JALR));
    cur.pred    = 1'b1;
    // target uses rs1 before the link overwrites it
    cur.exp_brj = (shadow[rs1] + sext12(imm)) & ~32'h1;
    write_reg(rd, cur.pc + 32'd4);
    push_row();
  endtask

  task automatic m_trap(input word_t instr, input logic ill, input logic ecall,
                        input logic ebreak);
    new_row(instr);
    cur.exp_exc.illegal = ill;
    cur.exp_exc.ecall   = ecall;
    cur.exp_exc.ebreak  = ebreak;
    cur.exp_halt        = ebreak;
    push_row();
  endtask

  // byte store shows the register as address, word store from x0 shows it as data
  task automatic expose(input logic [4:0] r);
    m_store(3'b000, r, r, 12'h000);
    m_store(3'b010, 5'd0, r, 12'h040);
  endtask

  task automatic build_table();
    logic [2:0]  load_kinds [5];
    logic [2:0]  br_kinds [6];
    logic [11:0] imm;
    word_t       rdata;
    load_kinds = '{LB, LH, LW, LBU, LHU};
    br_kinds   = '{BEQ, BNE, BLT, BGE, BLTU, BGEU};
    foreach (shadow[i]) shadow[i] = '0;
    model_pc    = 32'h0000_1000;
    model_stall = 1'b0;
    // registers read zero out of reset
    expose(5'd1);
    expose(5'd31);
    // random operands in x1 and x2
    m_lui(5'd1, 20'($urandom()));
    m_alu_imm(3'b000, 5'd1, 5'd1, 12'($urandom()));
    m_lui(5'd2, 20'($urandom()));
    m_alu_imm(3'b000, 5'd2, 5'd2, 12'($urandom()));
    expose(5'd1);
    expose(5'd2);
    for (int k = 0; k < 8; k++) begin
      m_alu_reg(3'(k), 7'h00, 5'd3, 5'd1, 5'd2);
      expose(5'd3);
    end
    m_alu_reg(3'b000, 7'h20, 5'd3, 5'd1, 5'd2);
    expose(5'd3);
    m_alu_reg(3'b101, 7'h20, 5'd3, 5'd1, 5'd2);
    expose(5'd3);
    for (int k = 0; k < 8; k++) begin
      imm = 12'($urandom());
      // shift immediates need a clean upper field
      if (k == 1 || k == 5) imm[11:5] = 7'h00;
      m_alu_imm(3'(k), 5'd4, 5'd1, imm);
      expose(5'd4);
    end
    m_alu_imm(3'b101, 5'd4, 5'd1, {7'h20, 5'($urandom())});
    expose(5'd4);
    // x0 ignores writes
    m_lui(5'd0, 20'($urandom()));
    m_alu_imm(3'b000, 5'd0, 5'd1, 12'h123);
    expose(5'd0);
    m_auipc(5'd5, 20'($urandom()));
    expose(5'd5);
    // word-aligned base in x6 for every size at every offset
    m_lui(5'd6, 20'($urandom()));
    for (int s = 0; s < 3; s++) begin
      for (int off = 0; off < 4; off++) m_store(3'(s), 5'd6, 5'd2, 12'(off));
    end
    for (int k = 0; k < 5; k++) begin
      for (int off = 0; off < 4; off++) begin
        rdata = $urandom();
        // sign bits set at offsets 1 and 2 so bytes and halves see both signs
        if (off == 1 || off == 2) rdata = rdata | 32'h8080_8080;
        else                      rdata = rdata & 32'h7f7f_7f7f;
        m_load(load_kinds[k], 5'd7, 5'd6, 12'(off), rdata);
        m_store(3'b010, 5'd0, 5'd7, 12'h080);
      end
    end
    // x9 equals x8, x10 differs
    m_lui(5'd8, 20'($urandom()));
    m_alu_imm(3'b000, 5'd8, 5'd8, 12'($urandom()));
    m_alu_imm(3'b000, 5'd9, 5'd8, 12'h000);
    m_lui(5'd10, 20'($urandom()));
    m_alu_imm(3'b000, 5'd10, 5'd10, 12'($urandom()));
    for (int k = 0; k < 6; k++) begin
      for (int p = 0; p < 2; p++) begin
        m_branch(br_kinds[k], 5'd8, 5'd9, 13'($urandom()) & ~13'h1, p[0]);
        m_branch(br_kinds[k], 5'd8, 5'd10, 13'($urandom()) & ~13'h1, p[0]);
        m_branch(br_kinds[k], 5'd10, 5'd8, 13'($urandom()) & ~13'h1, p[0]);
      end
    end
    m_jal(5'd11, 21'($urandom()) & ~21'h1);
    expose(5'd11);
    m_jalr(5'd12, 5'd8, 12'($urandom()));
    expose(5'd12);
    m_jalr(5'd8, 5'd8, 12'($urandom()));
    expose(5'd8);
    // stalled register write, store and load leave no trace
    model_stall = 1'b1;
    m_alu_imm(3'b000, 5'd1, 5'd1, 12'h7ff);
    m_store(3'b010, 5'd0, 5'd1, 12'h0c0);
    m_load(3'b010, 5'd2, 5'd6, 12'h000, $urandom());
    model_stall = 1'b0;
    expose(5'd1);
    expose(5'd2);
    // ecall, ebreak and three illegal words
    m_trap(32'h0000_0073, 1'b0, 1'b1, 1'b0);
    m_trap(32'h0010_0073, 1'b0, 1'b0, 1'b1);
    m_trap(32'h0000_0000, 1'b1, 1'b0, 1'b0);
    m_trap(enc_r(7'h01, 5'd2, 5'd1, 3'b000, 5'd3, OP_REG), 1'b1, 1'b0, 1'b0);
    m_trap(32'hffff_ffff, 1'b1, 1'b0, 1'b0);
    expose(5'd3);
  endtask

  task automatic check_word(input string name, input word_t exp, input word_t act);
    assert (act === exp) else begin
      $display("CHECK FAILED %s at %s expected 0x%h actual 0x%h", name, where_now, exp, act);
      $display("SIMULATION FAILED");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  task automatic check_row(input row_t r);
    check_word("brj_addr", r.exp_brj, brj_addr);
    check_word("mispredict", r.exp_misp, mispredict);
    check_word("halt", r.exp_halt, halt);
    check_word("exc", r.exp_exc, exc);
    check_word("dmem_req.ren", r.exp_req.ren, dmem_req.ren);
    check_word("dmem_req.wen", r.exp_req.wen, dmem_req.wen);
    // bus fields only mean something with a live request
    if (r.exp_req.ren || r.exp_req.wen) begin
      check_word("dmem_req.addr", r.exp_req.addr, dmem_req.addr);
      check_word("dmem_req.byte_en", r.exp_req.byte_en, dmem_req.byte_en);
    end
    if (r.exp_req.wen) check_word("dmem_req.wdata", r.exp_req.wdata, dmem_req.wdata);
  endtask

  // watchdog sized from the table length
  initial begin
    int n_cycles;
    wait (table_built === 1'b1);
    n_cycles = rows.size() + 20;
    #(n_cycles * CLK_PERIOD);
    $display("watchdog expired after %0d cycles before the table finished", n_cycles);
    $display("SIMULATION FAILED");
    $fatal(1, "timeout");
  end

  initial begin
    int seed_val;
    CLK         = 1'b0;
    arst_n      = 1'b0;
    fetch_ex    = '0;
    stall       = 1'b0;
    dmem_rdata  = '0;
    table_built = 1'b0;
    where_now   = "start";
    seed_val    = $urandom(94631);
    build_table();
    table_built = 1'b1;
    // in reset a taken branch, a store and a load must stay quiet
    for (int i = 0; i < 9; i++) begin
      @(negedge CLK);
      where_now = $sformatf("reset cycle %0d", i);
      case (i % 3)
        0:       fetch_ex.instr.raw = enc_b(13'h020, 5'd0, 5'd0, BEQ);
        1:       fetch_ex.instr.raw = enc_s(12'h010, 5'd0, 5'd0, 3'b010);
        default: fetch_ex.instr.raw = enc_i(12'h010, 5'd0, 3'b010, 5'd1, OP_LOAD);
      endcase
      fetch_ex.pc         = 32'h0000_0800;
      fetch_ex.prediction = 1'b0;
      #(CHECK_DELAY);
      check_word("dmem_req.ren", 1'b0, dmem_req.ren);
      check_word("dmem_req.wen", 1'b0, dmem_req.wen);
      check_word("mispredict", 1'b0, mispredict);
      check_word("brj_addr", RESET_PC, brj_addr);
    end
    // release with an all-zero word, which has no side effects
    @(negedge CLK);
    arst_n   = 1'b1;
    fetch_ex = '0;
    for (int i = 0; i < rows.size(); i++) begin
      @(negedge CLK);
      where_now           = $sformatf("row %0d", i);
      fetch_ex.instr.raw  = rows[i].instr;
      fetch_ex.pc         = rows[i].pc;
      fetch_ex.prediction = rows[i].pred;
      stall               = rows[i].stall;
      dmem_rdata          = rows[i].rdata;
      #(CHECK_DELAY);
      check_row(rows[i]);
    end
    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

//--- files.f
design/rv32_pkg.sv
design/instr_decoder.sv
design/reg_file.sv
design/alu.sv
design/branch_unit.sv
design/lsu_align.sv
design/execute_stage.sv
dv/execute_stage_tb.sv
